// File: Makefile
TOP = tb_sparse_dot

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@! grep -q "\*\* FAIL \*\*" sim.log
	@grep -q "\*\* PASS \*\*" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: chunk_store.sv
`timescale 1ns/1ps

module chunk_store (
	 input  logic                   clk_i
	,input  logic                   rst_i
	,input  logic                   wr_valid_i
	,input  sparse_pkg::wr_beat_t   wr_beat_i
	,input  sparse_pkg::win_addr_t  wr_count_i
	,input  sparse_pkg::win_addr_t  rd_win_i
	,output sparse_pkg::sparsemap_t rd_map_o
	,input  logic                   rd_en_i
	,input  sparse_pkg::bit_pos_t   rd_pos_i
	,output sparse_pkg::elem_t      rd_data_o
);

	import sparse_pkg::*;

	// Storage
	sparsemap_t map_mem  [WIN_NUM];
	data_addr_t base_mem [WIN_NUM];
	elem_t      data_mem [MEM_SIZE];

	data_addr_t wr_ptr_r;
	data_addr_t wr_base_w;
	data_addr_t wr_pop_w;
	data_addr_t rd_base_w;
	data_addr_t rd_addr_w;
	sparsemap_t below_w;

	function automatic data_addr_t popcount(input sparsemap_t map);
		data_addr_t cnt;
		cnt = '0;
		for (int i = 0; i < BUS_SIZE; i++) begin
			cnt = cnt + data_addr_t'(map[i]);
		end
		return cnt;
	endfunction

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////

	// Window 0 restarts the running prefix
	assign wr_base_w = (wr_count_i == '0) ? '0 : wr_ptr_r;
	assign wr_pop_w  = popcount(wr_beat_i.map);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_r <= '0;
		end
		else if (wr_valid_i) begin
			wr_ptr_r <= wr_base_w + wr_pop_w;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			map_mem[wr_count_i]  <= wr_beat_i.map;
			base_mem[wr_count_i] <= wr_base_w;
		end
	end

	// Append only the packed nonzero bytes
	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			for (int i = 0; i < BUS_SIZE; i++) begin
				if (data_addr_t'(i) < wr_pop_w) begin
					data_mem[(wr_base_w + data_addr_t'(i)) % MEM_SIZE] <= wr_beat_i.data[i];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////

	assign rd_map_o = map_mem[rd_win_i];

	// Bits below the match position
	assign below_w   = (sparsemap_t'(1) << rd_pos_i) - 1'b1;
	assign rd_base_w = base_mem[rd_win_i];
	assign rd_addr_w = rd_base_w + popcount(rd_map_o & below_w);

	// Registered gather
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			rd_data_o <= data_mem[rd_addr_w % MEM_SIZE];
		end
	end

endmodule

// File: dot_accumulator.sv
`timescale 1ns/1ps

module dot_accumulator (
	 input  logic              clk_i
	,input  logic              rst_i
	,input  logic              pair_valid_i
	,input  sparse_pkg::pair_t pair_i
	,input  logic              chunk_end_i
	,output logic              result_valid_o
	,output sparse_pkg::acc_t  result_o
);

	import sparse_pkg::*;

	logic signed [15:0] prod_w;
	acc_t               sum_w;
	acc_t               acc_r;
	logic               end_d_r;

	assign prod_w = $signed(pair_i.ifm) * $signed(pair_i.filter);

	// Includes the pair arriving this cycle
	assign sum_w = acc_r + (pair_valid_i ? acc_t'(prod_w) : '0);

	////////////////////////////////////////////////////////////
	// Accumulate and close
	////////////////////////////////////////////////////////////

	// Last pair trails chunk end by one cycle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			acc_r          <= '0;
			end_d_r        <= 1'b0;
			result_valid_o <= 1'b0;
		end
		else begin
			end_d_r        <= chunk_end_i;
			result_valid_o <= end_d_r;
			if (end_d_r) begin
				acc_r <= '0;
			end
			else begin
				acc_r <= sum_w;
			end
		end
	end

	// Held until the next run closes
	always_ff @(posedge clk_i) begin
		if (end_d_r) begin
			result_o <= sum_w;
		end
	end

endmodule

// File: input_selector.sv
`timescale 1ns/1ps

module input_selector (
	 input  logic                  clk_i
	,input  logic                  rst_i
	,input  logic                  chunk_start_i
	,input  logic                  run_i
	,input  sparse_pkg::win_addr_t rd_last_win_i

	,input  logic                  ifm_wr_valid_i
	,input  sparse_pkg::wr_beat_t  ifm_wr_beat_i
	,input  sparse_pkg::win_addr_t ifm_wr_count_i
	,input  logic                  filter_wr_valid_i
	,input  sparse_pkg::wr_beat_t  filter_wr_beat_i
	,input  sparse_pkg::win_addr_t filter_wr_count_i

	,output logic                  pair_valid_o
	,output sparse_pkg::pair_t     pair_o
	,output logic                  chunk_end_o
);

	import sparse_pkg::*;

	logic       busy_r;
	win_addr_t  win_addr_r;
	win_addr_t  win_addr_w;
	logic       enc_run_w;
	logic       match_valid_w;
	bit_pos_t   match_pos_w;
	logic       win_last_w;
	sparsemap_t ifm_map_w;
	sparsemap_t filter_map_w;
	elem_t      ifm_data_w;
	elem_t      filter_data_w;
	logic       pair_valid_r;

	////////////////////////////////////////////////////////////
	// Compressed stores
	////////////////////////////////////////////////////////////

	chunk_store ifm_store_i (
		 .clk_i
		,.rst_i
		,.wr_valid_i (ifm_wr_valid_i)
		,.wr_beat_i  (ifm_wr_beat_i)
		,.wr_count_i (ifm_wr_count_i)
		,.rd_win_i   (win_addr_w)
		,.rd_map_o   (ifm_map_w)
		,.rd_en_i    (match_valid_w)
		,.rd_pos_i   (match_pos_w)
		,.rd_data_o  (ifm_data_w)
	);

	chunk_store filter_store_i (
		 .clk_i
		,.rst_i
		,.wr_valid_i (filter_wr_valid_i)
		,.wr_beat_i  (filter_wr_beat_i)
		,.wr_count_i (filter_wr_count_i)
		,.rd_win_i   (win_addr_w)
		,.rd_map_o   (filter_map_w)
		,.rd_en_i    (match_valid_w)
		,.rd_pos_i   (match_pos_w)
		,.rd_data_o  (filter_data_w)
	);

	match_encoder match_encoder_i (
		 .clk_i
		,.rst_i
		,.run_i         (enc_run_w)
		,.new_win_i     (chunk_start_i)
		,.ifm_map_i     (ifm_map_w)
		,.filter_map_i  (filter_map_w)
		,.match_valid_o (match_valid_w)
		,.match_pos_o   (match_pos_w)
		,.win_last_o    (win_last_w)
	);

	////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////

	// Start cycle already works on window 0
	assign enc_run_w  = run_i && (busy_r || chunk_start_i);
	assign win_addr_w = chunk_start_i ? '0 : win_addr_r;

	assign chunk_end_o = win_last_w && (win_addr_w == rd_last_win_i);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_r     <= 1'b0;
			win_addr_r <= '0;
		end
		else if (chunk_end_o) begin
			busy_r     <= 1'b0;
			win_addr_r <= '0;
		end
		else if (win_last_w) begin
			busy_r     <= 1'b1;
			win_addr_r <= win_addr_w + 1'b1;
		end
		else if (chunk_start_i) begin
			busy_r     <= 1'b1;
			win_addr_r <= '0;
		end
	end

	// Pair lines up with the registered store read
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pair_valid_r <= 1'b0;
		end
		else begin
			pair_valid_r <= match_valid_w;
		end
	end

	assign pair_valid_o  = pair_valid_r;
	assign pair_o.ifm    = ifm_data_w;
	assign pair_o.filter = filter_data_w;

endmodule

// File: match_encoder.sv
`timescale 1ns/1ps

module match_encoder (
	 input  logic                   clk_i
	,input  logic                   rst_i
	,input  logic                   run_i
	,input  logic                   new_win_i
	,input  sparse_pkg::sparsemap_t ifm_map_i
	,input  sparse_pkg::sparsemap_t filter_map_i
	,output logic                   match_valid_o
	,output sparse_pkg::bit_pos_t   match_pos_o
	,output logic                   win_last_o
);

	import sparse_pkg::*;

	enc_state_t state_r;
	sparsemap_t mask_r;
	sparsemap_t cur_w;
	sparsemap_t low_bit_w;
	logic       active_w;

	////////////////////////////////////////////////////////////
	// Current window bits
	////////////////////////////////////////////////////////////

	// Fresh window takes the AND of both maps, else the leftover bits
	assign cur_w = (new_win_i || (state_r == ENC_NEW_WIN)) ?
		(ifm_map_i & filter_map_i) : mask_r;

	// Isolate lowest set bit
	assign low_bit_w = cur_w & (~cur_w + 1'b1);

	// Nothing loaded before the first start
	assign active_w = run_i && (new_win_i || (state_r != ENC_IDLE));

	// Priority encode, lowest index wins
	always_comb begin
		match_pos_o = '0;
		for (int i = BUS_SIZE - 1; i >= 0; i--) begin
			if (cur_w[i]) begin
				match_pos_o = bit_pos_t'(i);
			end
		end
	end

	assign match_valid_o = active_w && (cur_w != '0);

	// At most one bit left, so an empty window still takes one step
	assign win_last_o = active_w && ((cur_w & (cur_w - 1'b1)) == '0);

	////////////////////////////////////////////////////////////
	// Walk state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r <= ENC_IDLE;
			mask_r  <= '0;
		end
		else if (active_w) begin
			mask_r  <= cur_w & ~low_bit_w;
			state_r <= win_last_o ? ENC_NEW_WIN : ENC_WALK;
		end
		else if (new_win_i) begin
			// Start while stalled, load the maps once run returns
			state_r <= ENC_NEW_WIN;
		end
	end

endmodule

// File: sim.f
sparse_pkg.sv
match_encoder.sv
chunk_store.sv
input_selector.sv
dot_accumulator.sv
sparse_dot_top.sv
sparse_dot_asserts.sv
tb_sparse_dot.sv

// File: sparse_dot_asserts.sv
`timescale 1ns/1ps

module sparse_dot_asserts (
	 input logic clk_i
	,input logic rst_i
	,input logic chunk_start_i
	,input logic chunk_end_i
	,input logic pair_valid_i
	,input logic result_valid_i
);

	logic busy_r;
	int   fail_cnt = 0;

	// Run state as seen from the ports
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_r <= 1'b0;
		end
		else if (chunk_end_i) begin
			busy_r <= 1'b0;
		end
		else if (chunk_start_i) begin
			busy_r <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Result pulse
	////////////////////////////////////////////////////////////

	result_after_end: assert property (@(posedge clk_i) disable iff (rst_i)
		$past(chunk_end_i, 2) |-> result_valid_i)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("result_valid_o missing two cycles after chunk_end_o");
	end

	result_needs_end: assert property (@(posedge clk_i) disable iff (rst_i)
		result_valid_i |-> $past(chunk_end_i, 2))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("result_valid_o without chunk_end_o two cycles before");
	end

	result_single: assert property (@(posedge clk_i) disable iff (rst_i)
		$past(result_valid_i) |-> !result_valid_i)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("result_valid_o held longer than one cycle");
	end

	// Pairs only trail a working cycle
	pair_in_run: assert property (@(posedge clk_i) disable iff (rst_i)
		pair_valid_i |-> $past(chunk_start_i || busy_r))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("pair_valid_o more than one cycle after idle");
	end

	quiet_in_reset: assert property (@(posedge clk_i)
		$past(rst_i) |-> !pair_valid_i && !result_valid_i && !chunk_end_i)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("Output valid high during reset");
	end

endmodule

// File: sparse_dot_patterns.txt
// Word 0 is the test count. Per test: last window, 32 IFM bytes, 32 filter bytes,
// expected match count, expected sum as 24-bit two's complement (all hex)
05
// Dense chunk, all four windows
03
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
20 000020
// Disjoint sparsity, no matches
03
05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00 05 00
00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9 00 f9
00 000000
// Two windows, negative filter
01
02 00 00 00 02 00 00 00 02 00 00 00 02 00 00 00 02 00 00 00 02 00 00 00 02 00 00 00 02 00 00 00
ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03 ff 03
04 fffff8
// Window 0 only, extreme values
00
80 7f 00 03 00 00 fe 01 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09
80 80 05 00 00 04 fd 00 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 09
03 000086
// Three windows, empty window in the middle
02
00 01 02 00 03 00 04 00 00 00 00 00 00 00 00 00 ff fe fd fc fb fa f9 f8 10 10 10 10 10 10 10 10
05 06 00 00 07 08 09 00 01 01 01 01 01 01 01 01 00 00 00 00 00 00 00 02 10 10 10 10 10 10 10 10
04 00002f

// File: sparse_dot_top.sv
`timescale 1ns/1ps

module sparse_dot_top (
	 input  logic                  clk_i
	,input  logic                  rst_i

	// Compressed writes
	,input  logic                  ifm_wr_valid_i
	,input  sparse_pkg::wr_beat_t  ifm_wr_beat_i
	,input  sparse_pkg::win_addr_t ifm_wr_count_i
	,input  logic                  filter_wr_valid_i
	,input  sparse_pkg::wr_beat_t  filter_wr_beat_i
	,input  sparse_pkg::win_addr_t filter_wr_count_i

	// Run control
	,input  logic                  chunk_start_i
	,input  sparse_pkg::win_addr_t rd_last_win_i
	,input  logic                  run_i

	// Outputs
	,output logic                  pair_valid_o
	,output sparse_pkg::pair_t     pair_o
	,output logic                  chunk_end_o
	,output logic                  result_valid_o
	,output sparse_pkg::acc_t      result_o
);

	input_selector input_selector_i (
		 .clk_i
		,.rst_i
		,.chunk_start_i
		,.run_i
		,.rd_last_win_i
		,.ifm_wr_valid_i
		,.ifm_wr_beat_i
		,.ifm_wr_count_i
		,.filter_wr_valid_i
		,.filter_wr_beat_i
		,.filter_wr_count_i
		,.pair_valid_o
		,.pair_o
		,.chunk_end_o
	);

	// Pairs feed the accumulator directly
	dot_accumulator dot_accumulator_i (
		 .clk_i
		,.rst_i
		,.pair_valid_i   (pair_valid_o)
		,.pair_i         (pair_o)
		,.chunk_end_i    (chunk_end_o)
		,.result_valid_o
		,.result_o
	);

endmodule

// File: sparse_pkg.sv
package sparse_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Elements per write beat and per sparsemap window
	localparam int BUS_SIZE = 8;
	// Elements per chunk
	localparam int MEM_SIZE = 32;
	localparam int WIN_NUM  = MEM_SIZE / BUS_SIZE;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	// Nonzero flags of one window, bit i for element i
	typedef logic [BUS_SIZE-1:0] sparsemap_t;

	typedef logic signed [7:0] elem_t;

	typedef logic [$clog2(WIN_NUM)-1:0] win_addr_t;

	typedef logic [$clog2(BUS_SIZE)-1:0] bit_pos_t;

	// One extra bit so a full chunk count of 32 fits
	typedef logic [$clog2(MEM_SIZE):0] data_addr_t;

	typedef logic signed [23:0] acc_t;

	////////////////////////////////////////////////////////////
	// Grouped signals
	////////////////////////////////////////////////////////////

	// Compressed write beat, nonzero bytes packed from data[0] up
	typedef struct packed {
		sparsemap_t            map;
		elem_t [BUS_SIZE-1:0]  data;
	} wr_beat_t;

	// Matched operand pair
	typedef struct packed {
		elem_t ifm;
		elem_t filter;
	} pair_t;

	// Encoder state
	typedef enum logic [1:0] {
		ENC_IDLE,
		ENC_NEW_WIN,
		ENC_WALK
	} enc_state_t;

endpackage

// File: tb_sparse_dot.sv
`timescale 1ns/1ps

module tb_sparse_dot;

	import sparse_pkg::*;

	localparam int PAT_WORDS  = 1024;
	localparam int TEST_WORDS = 2 * MEM_SIZE + 3;
	localparam int RAND_RUNS  = 20;
	localparam int RUN_CYCLES = 60;
	localparam int RST_CYCLES = 8;

	logic        clk_i;
	logic        rst_i;
	logic        ifm_wr_valid_i;
	wr_beat_t    ifm_wr_beat_i;
	win_addr_t   ifm_wr_count_i;
	logic        filter_wr_valid_i;
	wr_beat_t    filter_wr_beat_i;
	win_addr_t   filter_wr_count_i;
	logic        chunk_start_i;
	win_addr_t   rd_last_win_i;
	logic        run_i;
	logic        pair_valid_o;
	pair_t       pair_o;
	logic        chunk_end_o;
	logic        result_valid_o;
	acc_t        result_o;

	logic [31:0] pat_mem [PAT_WORDS];
	elem_t       ifm_vec [MEM_SIZE];
	elem_t       filter_vec [MEM_SIZE];
	pair_t       exp_q [$];
	logic [31:0] lfsr_r;
	int          n_tests;
	int          checks;
	int          errors;
	int          assert_fails;
	int          pair_cnt;
	int          result_cnt;
	acc_t        result_seen;

	sparse_dot_top sparse_dot_top_i (.*);

	bind sparse_dot_top sparse_dot_asserts sparse_dot_asserts_i (
		 .clk_i          (clk_i)
		,.rst_i          (rst_i)
		,.chunk_start_i  (chunk_start_i)
		,.chunk_end_i    (chunk_end_o)
		,.pair_valid_i   (pair_valid_o)
		,.result_valid_i (result_valid_o)
	);

	always #5 clk_i = ~clk_i;

	////////////////////////////////////////////////////////////
	// Random source and vector packing
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
		lfsr_r = {lfsr_r[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic logic next_run(input logic stalls);
		return stalls ? (rand_bits(2) != 0) : 1'b1;
	endfunction

	// Nonzero bytes packed from data[0] up
	function automatic wr_beat_t pack_beat(input int w, input logic is_ifm);
		wr_beat_t b;
		elem_t    e;
		int       k;
		b = '0;
		k = 0;
		for (int i = 0; i < BUS_SIZE; i++) begin
			e = is_ifm ? ifm_vec[w * BUS_SIZE + i] : filter_vec[w * BUS_SIZE + i];
			if (e != 0) begin
				b.map[i]  = 1'b1;
				b.data[k] = e;
				k++;
			end
		end
		return b;
	endfunction

	task automatic random_vectors();
		logic [1:0] ifm_dens;
		logic [1:0] filter_dens;
		ifm_dens    = rand_bits(2);
		filter_dens = rand_bits(2);
		for (int i = 0; i < MEM_SIZE; i++) begin
			ifm_vec[i]    = (rand_bits(2) < ifm_dens) ? '0 : elem_t'(rand_bits(8));
			filter_vec[i] = (rand_bits(2) < filter_dens) ? '0 : elem_t'(rand_bits(8));
		end
	endtask

	// Dense reference over the selected windows
	task automatic build_expected(input win_addr_t last, output int cnt, output acc_t sum);
		pair_t p;
		cnt = 0;
		sum = '0;
		exp_q.delete();
		for (int i = 0; i < BUS_SIZE * (int'(last) + 1); i++) begin
			if (ifm_vec[i] != 0 && filter_vec[i] != 0) begin
				p.ifm    = ifm_vec[i];
				p.filter = filter_vec[i];
				exp_q.push_back(p);
				cnt++;
				sum = sum + acc_t'(ifm_vec[i]) * acc_t'(filter_vec[i]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////////////////////////

	task automatic check_value(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Fail at %0t ns: %s", $time, what);
		end
	endtask

	task automatic write_chunk();
		for (int w = 0; w < WIN_NUM; w++) begin
			@(negedge clk_i);
			ifm_wr_valid_i    = 1'b1;
			ifm_wr_beat_i     = pack_beat(w, 1'b1);
			ifm_wr_count_i    = win_addr_t'(w);
			filter_wr_valid_i = 1'b1;
			filter_wr_beat_i  = pack_beat(w, 1'b0);
			filter_wr_count_i = win_addr_t'(w);
		end
		@(negedge clk_i);
		ifm_wr_valid_i    = 1'b0;
		filter_wr_valid_i = 1'b0;
	endtask

	// Registered outputs, stable at the falling edge
	task automatic sample_outputs();
		pair_t p;
		if (pair_valid_o) begin
			pair_cnt++;
			assert (exp_q.size() > 0) else begin
				errors++;
				$display("Unexpected pair at %0t ns after all matches were seen", $time);
			end
			if (exp_q.size() > 0) begin
				p = exp_q.pop_front();
				check_value(pair_o == p, $sformatf("pair %h, expected %h", pair_o, p));
			end
		end
		if (result_valid_o) begin
			result_cnt++;
			result_seen = result_o;
		end
	endtask

	task automatic run_chunk(input win_addr_t last, input int exp_cnt, input acc_t exp_sum,
		input logic stalls);
		write_chunk();
		pair_cnt   = 0;
		result_cnt = 0;
		@(negedge clk_i);
		chunk_start_i = 1'b1;
		rd_last_win_i = last;
		run_i         = next_run(stalls);
		do begin
			@(negedge clk_i);
			chunk_start_i = 1'b0;
			sample_outputs();
			run_i = next_run(stalls);
		end while (result_cnt == 0);
		// Catch a stray second pulse
		repeat (3) begin
			@(negedge clk_i);
			sample_outputs();
		end
		run_i = 1'b0;
		check_value(result_cnt == 1, $sformatf("%0d result pulses, expected 1", result_cnt));
		check_value(pair_cnt == exp_cnt, $sformatf("%0d pairs, expected %0d", pair_cnt, exp_cnt));
		check_value(result_seen == exp_sum,
			$sformatf("result %0d, expected %0d", result_seen, exp_sum));
		check_value(result_o == exp_sum, $sformatf("held result %0d, expected %0d",
			result_o, exp_sum));
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int        base;
		int        cnt;
		acc_t      sum;
		win_addr_t last;
		clk_i             = 1'b0;
		rst_i             = 1'b1;
		ifm_wr_valid_i    = 1'b0;
		ifm_wr_beat_i     = '0;
		ifm_wr_count_i    = '0;
		filter_wr_valid_i = 1'b0;
		filter_wr_beat_i  = '0;
		filter_wr_count_i = '0;
		chunk_start_i     = 1'b0;
		rd_last_win_i     = '0;
		run_i             = 1'b0;
		lfsr_r            = 32'h6a33;
		checks            = 0;
		errors            = 0;
		$readmemh("sparse_dot_patterns.txt", pat_mem);
		n_tests = int'(pat_mem[0]);
		repeat (RST_CYCLES) @(negedge clk_i);
		rst_i = 1'b0;
		for (int t = 0; t < n_tests; t++) begin
			base = 1 + t * TEST_WORDS;
			last = win_addr_t'(pat_mem[base]);
			for (int i = 0; i < MEM_SIZE; i++) begin
				ifm_vec[i]    = elem_t'(pat_mem[base + 1 + i]);
				filter_vec[i] = elem_t'(pat_mem[base + 1 + MEM_SIZE + i]);
			end
			build_expected(last, cnt, sum);
			run_chunk(last, int'(pat_mem[base + 2 * MEM_SIZE + 1]),
				acc_t'(pat_mem[base + 2 * MEM_SIZE + 2]), t % 2 == 1);
		end
		for (int r = 0; r < RAND_RUNS; r++) begin
			random_vectors();
			last = win_addr_t'(rand_bits(2));
			build_expected(last, cnt, sum);
			run_chunk(last, cnt, sum, 1'b1);
		end
		assert_fails = sparse_dot_top_i.sparse_dot_asserts_i.fail_cnt;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("** PASS **");
		end
		else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog, budget per run
	initial begin
		#1;
		repeat ((n_tests + RAND_RUNS) * RUN_CYCLES + RST_CYCLES) @(posedge clk_i);
		$display("Watchdog expired before all runs finished");
		$display("** FAIL **");
		$finish;
	end

endmodule
